/* design/exec_pkg.sv */
`default_nettype none

package exec_pkg;

  // datapath width of one general register
  parameter int XLEN = 64;

  // reorder-buffer index width
  parameter int ROB_IDX_W = 6;

  // alu opcodes
  // the cs* family picks a or a modified b on a condition
  typedef enum logic [3:0] {
    alu_plus  = 4'd0,
    alu_minus = 4'd1,
    alu_orn   = 4'd2,
    alu_or    = 4'd3,
    alu_eor   = 4'd4,
    alu_and   = 4'd5,
    alu_csel  = 4'd6,
    alu_csinc = 4'd7,
    alu_csinv = 4'd8,
    alu_csneg = 4'd9
  } alu_op_t;

  // arm condition codes, standard encoding order
  typedef enum logic [3:0] {
    cond_eq = 4'h0,
    cond_ne = 4'h1,
    cond_cs = 4'h2,
    cond_cc = 4'h3,
    cond_mi = 4'h4,
    cond_pl = 4'h5,
    cond_vs = 4'h6,
    cond_vc = 4'h7,
    cond_hi = 4'h8,
    cond_ls = 4'h9,
    cond_ge = 4'ha,
    cond_lt = 4'hb,
    cond_gt = 4'hc,
    cond_le = 4'hd,
    cond_al = 4'he,
    cond_nv = 4'hf
  } cond_t;

  // memory op kind
  typedef enum logic {
    ls_load  = 1'b0,
    ls_store = 1'b1
  } ls_op_t;

  // source unit of a writeback
  typedef enum logic {
    unit_alu = 1'b0,
    unit_lsu = 1'b1
  } unit_t;

  // bit positions inside a 4-bit nzcv vector
  parameter int NZCV_N = 3;
  parameter int NZCV_Z = 2;
  parameter int NZCV_C = 1;
  parameter int NZCV_V = 0;

endpackage

`default_nettype wire

/* design/cond_eval.sv */
`timescale 1ns/1ps
`default_nettype none

module cond_eval import exec_pkg::*; (
  input  cond_t      cond,
  input  logic [3:0] nzcv,
  output logic       holds
);

  logic n;
  logic z;
  logic c;
  logic v;

  // split flags for readability
  assign n = nzcv[NZCV_N];
  assign z = nzcv[NZCV_Z];
  assign c = nzcv[NZCV_C];
  assign v = nzcv[NZCV_V];

  always_comb begin
    case (cond)
      cond_eq: holds = z;
      cond_ne: holds = !z;
      cond_cs: holds = c;
      cond_cc: holds = !c;
      cond_mi: holds = n;
      cond_pl: holds = !n;
      cond_vs: holds = v;
      cond_vc: holds = !v;
      // unsigned higher / lower-or-same
      cond_hi: holds = c && !z;
      cond_ls: holds = !c || z;
      // signed compares
      cond_ge: holds = (n == v);
      cond_lt: holds = (n != v);
      cond_gt: holds = !z && (n == v);
      cond_le: holds = z || (n != v);
      // al and nv both always hold
      default: holds = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

/* design/alu_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_unit import exec_pkg::*; (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 start,
  input  alu_op_t              op,
  input  cond_t                cond,
  input  logic [XLEN-1:0]      a,
  input  logic [XLEN-1:0]      b,
  input  logic [3:0]           nzcv_in,
  input  logic                 set_flags,
  input  logic [ROB_IDX_W-1:0] tag,
  output logic                 res_valid,
  output logic [XLEN-1:0]      res_value,
  output logic [3:0]           res_nzcv,
  output logic                 res_set_flags,
  output logic [ROB_IDX_W-1:0] res_tag
);

  // issued op, captured on start
  logic                 v_q;
  alu_op_t              op_q;
  cond_t                cond_q;
  logic [XLEN-1:0]      a_q;
  logic [XLEN-1:0]      b_q;
  logic [3:0]           nzcv_q;
  logic                 set_q;
  logic [ROB_IDX_W-1:0] tag_q;

  // extra top bit holds the carry out
  logic [XLEN:0]        r;
  logic                 holds;
  logic [3:0]           flags;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      v_q <= 1'b0;
    end else begin
      v_q <= start;
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      op_q   <= op;
      cond_q <= cond;
      a_q    <= a;
      b_q    <= b;
      nzcv_q <= nzcv_in;
      set_q  <= set_flags;
      tag_q  <= tag;
    end
  end

  // condition checked against the incoming flags
  cond_eval u_cond (
    .cond  (cond_q),
    .nzcv  (nzcv_q),
    .holds (holds)
  );

  always_comb begin
    case (op_q)
      alu_plus:  r = {1'b0, a_q} + {1'b0, b_q};
      // a + ~b + 1, carry out means no borrow
      alu_minus: r = {1'b0, a_q} + {1'b0, ~b_q} + {{XLEN{1'b0}}, 1'b1};
      alu_orn:   r = {1'b0, a_q | ~b_q};
      alu_or:    r = {1'b0, a_q | b_q};
      alu_eor:   r = {1'b0, a_q ^ b_q};
      alu_and:   r = {1'b0, a_q & b_q};
      alu_csel:  r = {1'b0, holds ? a_q : b_q};
      alu_csinc: r = {1'b0, holds ? a_q : b_q + 1'b1};
      alu_csinv: r = {1'b0, holds ? a_q : ~b_q};
      alu_csneg: r = {1'b0, holds ? a_q : ~b_q + 1'b1};
      default:   r = '0;
    endcase
  end

  always_comb begin
    flags         = 4'b0000;
    flags[NZCV_N] = r[XLEN-1];
    flags[NZCV_Z] = (r[XLEN-1:0] == '0);
    // c and v only for the arithmetic ops
    if (op_q == alu_plus) begin
      flags[NZCV_C] = r[XLEN];
      flags[NZCV_V] = (a_q[XLEN-1] == b_q[XLEN-1]) && (r[XLEN-1] != a_q[XLEN-1]);
    end else if (op_q == alu_minus) begin
      flags[NZCV_C] = r[XLEN];
      flags[NZCV_V] = (a_q[XLEN-1] != b_q[XLEN-1]) && (r[XLEN-1] != a_q[XLEN-1]);
    end
  end

  assign res_valid     = v_q;
  assign res_value     = r[XLEN-1:0];
  assign res_nzcv      = set_q ? flags : nzcv_q;
  assign res_set_flags = set_q;
  assign res_tag       = tag_q;

  // a live stage must hold a defined opcode
  a_op_defined: assert property (@(posedge clk) disable iff (!arst_n)
    v_q |-> (op_q <= alu_csneg));

endmodule

`default_nettype wire

/* design/data_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module data_mem import exec_pkg::*; #(
  parameter int MEM_BYTES = 1024
) (
  input  logic                         clk,
  input  logic [$clog2(MEM_BYTES)-1:0] addr,
  input  logic                         wen,
  input  logic [XLEN-1:0]              wdata,
  output logic [XLEN-1:0]              rdata
);

  localparam int AW    = $clog2(MEM_BYTES);
  localparam int BYTES = XLEN / 8;

  // byte array, zero at time 0
  logic [7:0] mem [MEM_BYTES] = '{default: 8'h00};

  always_ff @(posedge clk) begin
    if (wen) begin
      // little endian, byte 0 at the lowest address
      for (int i = 0; i < BYTES; i++) begin
        mem[addr + AW'(i)] <= wdata[8*i +: 8];
      end
      // write-through so a store sees its own data
      rdata <= wdata;
    end else begin
      for (int i = 0; i < BYTES; i++) begin
        rdata[8*i +: 8] <= mem[addr + AW'(i)];
      end
    end
  end

endmodule

`default_nettype wire

/* design/lsu_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_unit import exec_pkg::*; #(
  parameter int MEM_BYTES = 1024
) (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 start,
  input  ls_op_t               op,
  input  logic [XLEN-1:0]      base,
  input  logic [XLEN-1:0]      offset,
  input  logic [XLEN-1:0]      wdata,
  input  logic [ROB_IDX_W-1:0] tag,
  output logic                 res_valid,
  output logic [XLEN-1:0]      res_value,
  output logic [ROB_IDX_W-1:0] res_tag
);

  localparam int AW = $clog2(MEM_BYTES);

  // effective address before and after alignment
  logic [XLEN-1:0]      ea;
  logic [XLEN-1:0]      ea_aligned;

  // stage one, address and op
  logic                 v1_q;
  ls_op_t               op1_q;
  logic [AW-1:0]        addr1_q;
  logic [XLEN-1:0]      wdata1_q;
  logic [ROB_IDX_W-1:0] tag1_q;

  // stage two, memory access done
  logic                 v2_q;
  logic [ROB_IDX_W-1:0] tag2_q;

  logic                 mem_wen;
  logic [XLEN-1:0]      mem_rdata;

  assign ea         = base + offset;
  assign ea_aligned = {ea[XLEN-1:3], 3'b000};

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      v1_q <= 1'b0;
      v2_q <= 1'b0;
    end else begin
      v1_q <= start;
      v2_q <= v1_q;
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      op1_q    <= op;
      // only the bits that reach the memory
      addr1_q  <= ea_aligned[AW-1:0];
      wdata1_q <= wdata;
      tag1_q   <= tag;
    end
    tag2_q <= tag1_q;
  end

  // write only for a live store
  assign mem_wen = v1_q && (op1_q == ls_store);

  data_mem #(
    .MEM_BYTES (MEM_BYTES)
  ) u_mem (
    .clk   (clk),
    .addr  (addr1_q),
    .wen   (mem_wen),
    .wdata (wdata1_q),
    .rdata (mem_rdata)
  );

  // loads see the word, stores see their own data
  assign res_valid = v2_q;
  assign res_value = mem_rdata;
  assign res_tag   = tag2_q;

  // issuer must supply 64-bit aligned accesses
  a_aligned: assert property (@(posedge clk) disable iff (!arst_n)
    start |-> (ea[2:0] == 3'b000));

endmodule

`default_nettype wire

/* design/result_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module result_arbiter import exec_pkg::*; #(
  parameter int ALU_CREDITS = 4,
  parameter int LS_CREDITS  = 4,
  parameter int ROB_CREDITS = 2
) (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 alu_valid,
  input  logic [XLEN-1:0]      alu_value,
  input  logic [3:0]           alu_nzcv,
  input  logic                 alu_set_flags,
  input  logic [ROB_IDX_W-1:0] alu_tag,
  input  logic                 ls_valid,
  input  logic [XLEN-1:0]      ls_value,
  input  logic [ROB_IDX_W-1:0] ls_tag,
  input  logic                 rob_credit,
  output logic                 alu_credit,
  output logic                 ls_credit,
  output logic                 rob_done,
  output logic [ROB_IDX_W-1:0] rob_tag,
  output logic [XLEN-1:0]      rob_value,
  output logic                 rob_set_flags,
  output logic [3:0]           rob_nzcv,
  output unit_t                rob_unit
);

  // pointer and count widths, depth need not be a power of two
  localparam int AP_W = (ALU_CREDITS > 1) ? $clog2(ALU_CREDITS) : 1;
  localparam int LP_W = (LS_CREDITS > 1) ? $clog2(LS_CREDITS) : 1;
  localparam int AC_W = $clog2(ALU_CREDITS + 1);
  localparam int LC_W = $clog2(LS_CREDITS + 1);
  localparam int SC_W = $clog2(ROB_CREDITS + 1);

  // alu result buffer
  logic [XLEN-1:0]      alu_val_buf [ALU_CREDITS];
  logic [3:0]           alu_nzcv_buf [ALU_CREDITS];
  logic                 alu_sf_buf [ALU_CREDITS];
  logic [ROB_IDX_W-1:0] alu_tag_buf [ALU_CREDITS];
  logic [AP_W-1:0]      alu_wr;
  logic [AP_W-1:0]      alu_rd;
  logic [AC_W-1:0]      alu_cnt;

  // lsu result buffer, no flags
  logic [XLEN-1:0]      ls_val_buf [LS_CREDITS];
  logic [ROB_IDX_W-1:0] ls_tag_buf [LS_CREDITS];
  logic [LP_W-1:0]      ls_wr;
  logic [LP_W-1:0]      ls_rd;
  logic [LC_W-1:0]      ls_cnt;

  // free rob slots and next unit to favour
  logic [SC_W-1:0]      slots;
  unit_t                rr;
  logic                 pop_alu;
  logic                 pop_ls;

  // alternate on contention, else take the non-empty one
  assign pop_alu = (slots != '0) && (alu_cnt != '0) && ((ls_cnt == '0) || (rr == unit_alu));
  assign pop_ls  = (slots != '0) && (ls_cnt != '0) && !pop_alu;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      alu_wr  <= '0;
      alu_rd  <= '0;
      alu_cnt <= '0;
      ls_wr   <= '0;
      ls_rd   <= '0;
      ls_cnt  <= '0;
    end else begin
      if (alu_valid) begin
        alu_wr <= (alu_wr == AP_W'(ALU_CREDITS - 1)) ? '0 : alu_wr + 1'b1;
      end
      if (pop_alu) begin
        alu_rd <= (alu_rd == AP_W'(ALU_CREDITS - 1)) ? '0 : alu_rd + 1'b1;
      end
      if (ls_valid) begin
        ls_wr <= (ls_wr == LP_W'(LS_CREDITS - 1)) ? '0 : ls_wr + 1'b1;
      end
      if (pop_ls) begin
        ls_rd <= (ls_rd == LP_W'(LS_CREDITS - 1)) ? '0 : ls_rd + 1'b1;
      end
      alu_cnt <= alu_cnt + AC_W'(alu_valid) - AC_W'(pop_alu);
      ls_cnt  <= ls_cnt + LC_W'(ls_valid) - LC_W'(pop_ls);
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      slots      <= SC_W'(ROB_CREDITS);
      rr         <= unit_alu;
      rob_done   <= 1'b0;
      alu_credit <= 1'b0;
      ls_credit  <= 1'b0;
    end else begin
      // one slot spent per writeback, one back per rob_credit
      slots      <= slots - SC_W'(pop_alu || pop_ls) + SC_W'(rob_credit);
      rob_done   <= pop_alu || pop_ls;
      alu_credit <= pop_alu;
      ls_credit  <= pop_ls;
      if (pop_alu) begin
        rr <= unit_lsu;
      end else if (pop_ls) begin
        rr <= unit_alu;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (alu_valid) begin
      alu_val_buf[alu_wr]  <= alu_value;
      alu_nzcv_buf[alu_wr] <= alu_nzcv;
      alu_sf_buf[alu_wr]   <= alu_set_flags;
      alu_tag_buf[alu_wr]  <= alu_tag;
    end
    if (ls_valid) begin
      ls_val_buf[ls_wr] <= ls_value;
      ls_tag_buf[ls_wr] <= ls_tag;
    end
  end

  // registered writeback payload
  always_ff @(posedge clk) begin
    if (pop_alu) begin
      rob_tag       <= alu_tag_buf[alu_rd];
      rob_value     <= alu_val_buf[alu_rd];
      rob_set_flags <= alu_sf_buf[alu_rd];
      rob_nzcv      <= alu_nzcv_buf[alu_rd];
      rob_unit      <= unit_alu;
    end else if (pop_ls) begin
      rob_tag       <= ls_tag_buf[ls_rd];
      rob_value     <= ls_val_buf[ls_rd];
      // lsu never touches flags
      rob_set_flags <= 1'b0;
      rob_nzcv      <= 4'b0000;
      rob_unit      <= unit_lsu;
    end
  end

  // issuer credits must keep both buffers from overflowing
  a_alu_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
    alu_valid |-> (alu_cnt < AC_W'(ALU_CREDITS)));
  a_ls_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
    ls_valid |-> (ls_cnt < LC_W'(LS_CREDITS)));

  // rob must not return more slots than it owns
  a_slots_bound: assert property (@(posedge clk) disable iff (!arst_n)
    slots <= SC_W'(ROB_CREDITS));

endmodule

`default_nettype wire

/* design/func_units.sv */
`timescale 1ns/1ps
`default_nettype none

module func_units import exec_pkg::*; #(
  parameter int MEM_BYTES   = 1024,
  parameter int ALU_CREDITS = 4,
  parameter int LS_CREDITS  = 4,
  parameter int ROB_CREDITS = 2
) (
  input  logic                 clk,
  input  logic                 arst_n,
  // alu issue
  input  logic                 alu_start,
  input  alu_op_t              alu_op,
  input  cond_t                alu_cond,
  input  logic [XLEN-1:0]      alu_a,
  input  logic [XLEN-1:0]      alu_b,
  input  logic [3:0]           alu_nzcv_in,
  input  logic                 alu_set_flags,
  input  logic [ROB_IDX_W-1:0] alu_tag,
  output logic                 alu_credit,
  // load/store issue
  input  logic                 ls_start,
  input  ls_op_t               ls_op,
  input  logic [XLEN-1:0]      ls_base,
  input  logic [XLEN-1:0]      ls_offset,
  input  logic [XLEN-1:0]      ls_wdata,
  input  logic [ROB_IDX_W-1:0] ls_tag,
  output logic                 ls_credit,
  // rob writeback
  input  logic                 rob_credit,
  output logic                 rob_done,
  output logic [ROB_IDX_W-1:0] rob_tag,
  output logic [XLEN-1:0]      rob_value,
  output logic                 rob_set_flags,
  output logic [3:0]           rob_nzcv,
  output unit_t                rob_unit
);

  // alu to arbiter
  logic                 alu_res_valid;
  logic [XLEN-1:0]      alu_res_value;
  logic [3:0]           alu_res_nzcv;
  logic                 alu_res_set_flags;
  logic [ROB_IDX_W-1:0] alu_res_tag;

  // lsu to arbiter
  logic                 ls_res_valid;
  logic [XLEN-1:0]      ls_res_value;
  logic [ROB_IDX_W-1:0] ls_res_tag;

  alu_unit u_alu (
    .clk           (clk),
    .arst_n        (arst_n),
    .start         (alu_start),
    .op            (alu_op),
    .cond          (alu_cond),
    .a             (alu_a),
    .b             (alu_b),
    .nzcv_in       (alu_nzcv_in),
    .set_flags     (alu_set_flags),
    .tag           (alu_tag),
    .res_valid     (alu_res_valid),
    .res_value     (alu_res_value),
    .res_nzcv      (alu_res_nzcv),
    .res_set_flags (alu_res_set_flags),
    .res_tag       (alu_res_tag)
  );

  lsu_unit #(
    .MEM_BYTES (MEM_BYTES)
  ) u_lsu (
    .clk       (clk),
    .arst_n    (arst_n),
    .start     (ls_start),
    .op        (ls_op),
    .base      (ls_base),
    .offset    (ls_offset),
    .wdata     (ls_wdata),
    .tag       (ls_tag),
    .res_valid (ls_res_valid),
    .res_value (ls_res_value),
    .res_tag   (ls_res_tag)
  );

  result_arbiter #(
    .ALU_CREDITS (ALU_CREDITS),
    .LS_CREDITS  (LS_CREDITS),
    .ROB_CREDITS (ROB_CREDITS)
  ) u_arb (
    .clk           (clk),
    .arst_n        (arst_n),
    .alu_valid     (alu_res_valid),
    .alu_value     (alu_res_value),
    .alu_nzcv      (alu_res_nzcv),
    .alu_set_flags (alu_res_set_flags),
    .alu_tag       (alu_res_tag),
    .ls_valid      (ls_res_valid),
    .ls_value      (ls_res_value),
    .ls_tag        (ls_res_tag),
    .rob_credit    (rob_credit),
    .alu_credit    (alu_credit),
    .ls_credit     (ls_credit),
    .rob_done      (rob_done),
    .rob_tag       (rob_tag),
    .rob_value     (rob_value),
    .rob_set_flags (rob_set_flags),
    .rob_nzcv      (rob_nzcv),
    .rob_unit      (rob_unit)
  );

endmodule

`default_nettype wire

/* dv/func_units_ref.svh */
`ifndef FUNC_UNITS_REF_SVH
`define FUNC_UNITS_REF_SVH

// word-wide view of the data memory, updated in issue order
logic [XLEN-1:0] mem_model [MEM_BYTES/8] = '{default: '0};

// arm condition check, pairs of codes share a test and the odd one inverts it
function automatic logic cond_holds(input cond_t cond, input logic [3:0] f);
  logic n;
  logic z;
  logic c;
  logic v;
  logic r;
  n = f[NZCV_N];
  z = f[NZCV_Z];
  c = f[NZCV_C];
  v = f[NZCV_V];
  case (cond[3:1])
    3'd0: r = z;
    3'd1: r = c;
    3'd2: r = n;
    3'd3: r = v;
    3'd4: r = c && !z;
    3'd5: r = (n == v);
    3'd6: r = (n == v) && !z;
    default: r = 1'b1;
  endcase
  // nv is the one odd code that still holds
  if (cond[0] && (cond != cond_nv)) begin
    r = !r;
  end
  return r;
endfunction

// expected {nzcv, value} of one alu op
function automatic logic [XLEN+3:0] alu_expect(input alu_op_t op, input cond_t cond,
                                                input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b,
                                                input logic [3:0] nzcv_in,
                                                input logic set_flags);
  logic [XLEN:0]   sum;
  logic [XLEN-1:0] r;
  logic            c;
  logic            v;
  logic            take_a;
  logic [3:0]      f;
  c      = 1'b0;
  v      = 1'b0;
  take_a = cond_holds(cond, nzcv_in);
  case (op)
    alu_plus: begin
      sum = {1'b0, a} + {1'b0, b};
      r   = sum[XLEN-1:0];
      c   = sum[XLEN];
      // both operands disagree in sign with the sum
      v   = (a[XLEN-1] ^ r[XLEN-1]) & (b[XLEN-1] ^ r[XLEN-1]);
    end
    alu_minus: begin
      r = a - b;
      // carry set means no borrow
      c = (a >= b);
      v = (a[XLEN-1] ^ b[XLEN-1]) & (a[XLEN-1] ^ r[XLEN-1]);
    end
    alu_orn:   r = a | ~b;
    alu_or:    r = a | b;
    alu_eor:   r = a ^ b;
    alu_and:   r = a & b;
    alu_csel:  r = take_a ? a : b;
    alu_csinc: r = take_a ? a : b + 1;
    alu_csinv: r = take_a ? a : ~b;
    alu_csneg: r = take_a ? a : -b;
    default:   r = '0;
  endcase
  f = nzcv_in;
  if (set_flags) begin
    f[NZCV_N] = r[XLEN-1];
    f[NZCV_Z] = (r == '0);
    f[NZCV_C] = c;
    f[NZCV_V] = v;
  end
  return {f, r};
endfunction

// load returns the word, store updates it and returns its data
function automatic logic [XLEN-1:0] ls_expect(input ls_op_t op, input logic [AW-4:0] idx,
                                              input logic [XLEN-1:0] wdata);
  if (op == ls_store) begin
    mem_model[idx] = wdata;
    return wdata;
  end
  return mem_model[idx];
endfunction

`endif

/* dv/func_units_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module func_units_tb import exec_pkg::*; ();

  localparam int MEM_BYTES   = 1024;
  localparam int ALU_CREDITS = 4;
  localparam int LS_CREDITS  = 4;
  localparam int ROB_CREDITS = 2;
  localparam int AW          = $clog2(MEM_BYTES);
  // expected entry is {set_flags, nzcv, tag, value}
  localparam int EXP_W       = 1 + 4 + ROB_IDX_W + XLEN;
  localparam int RAND_CYCLES = 3000;
  localparam int TIMEOUT     = 2000;

  logic                 clk;
  logic                 arst_n;
  logic                 alu_start;
  alu_op_t              alu_op;
  cond_t                alu_cond;
  logic [XLEN-1:0]      alu_a;
  logic [XLEN-1:0]      alu_b;
  logic [3:0]           alu_nzcv_in;
  logic                 alu_set_flags;
  logic [ROB_IDX_W-1:0] alu_tag;
  logic                 alu_credit;
  logic                 ls_start;
  ls_op_t               ls_op;
  logic [XLEN-1:0]      ls_base;
  logic [XLEN-1:0]      ls_offset;
  logic [XLEN-1:0]      ls_wdata;
  logic [ROB_IDX_W-1:0] ls_tag;
  logic                 ls_credit;
  logic                 rob_credit;
  logic                 rob_done;
  logic [ROB_IDX_W-1:0] rob_tag;
  logic [XLEN-1:0]      rob_value;
  logic                 rob_set_flags;
  logic [3:0]           rob_nzcv;
  unit_t                rob_unit;

  integer               seed = 32'h5cc9_3527;
  // station side credits and rob side slot bookkeeping
  int                   alu_held;
  int                   ls_held;
  int                   slots_free;
  int                   rob_owed;
  int                   hold_cycles;
  logic [ROB_IDX_W-1:0] tag_next;
  logic [EXP_W-1:0]     alu_exp_q [$];
  logic [EXP_W-1:0]     ls_exp_q [$];

  `include "func_units_ref.svh"

  always #2 clk = ~clk;

  func_units #(
    .MEM_BYTES   (MEM_BYTES),
    .ALU_CREDITS (ALU_CREDITS),
    .LS_CREDITS  (LS_CREDITS),
    .ROB_CREDITS (ROB_CREDITS)
  ) uut (
    .clk           (clk),
    .arst_n        (arst_n),
    .alu_start     (alu_start),
    .alu_op        (alu_op),
    .alu_cond      (alu_cond),
    .alu_a         (alu_a),
    .alu_b         (alu_b),
    .alu_nzcv_in   (alu_nzcv_in),
    .alu_set_flags (alu_set_flags),
    .alu_tag       (alu_tag),
    .alu_credit    (alu_credit),
    .ls_start      (ls_start),
    .ls_op         (ls_op),
    .ls_base       (ls_base),
    .ls_offset     (ls_offset),
    .ls_wdata      (ls_wdata),
    .ls_tag        (ls_tag),
    .ls_credit     (ls_credit),
    .rob_credit    (rob_credit),
    .rob_done      (rob_done),
    .rob_tag       (rob_tag),
    .rob_value     (rob_value),
    .rob_set_flags (rob_set_flags),
    .rob_nzcv      (rob_nzcv),
    .rob_unit      (rob_unit)
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [XLEN-1:0] got,
                             input logic [XLEN-1:0] exp);
    if (got !== exp) abort_run($sformatf("FAIL %s: got %h expected %h", name, got, exp));
  endtask

  task automatic check_nzcv(input string name, input logic [3:0] got, input logic [3:0] exp);
    if (got !== exp) abort_run($sformatf("FAIL %s: got %h expected %h", name, got, exp));
  endtask

  task automatic check_tag(input string name, input logic [ROB_IDX_W-1:0] got,
                           input logic [ROB_IDX_W-1:0] exp);
    if (got !== exp) abort_run($sformatf("FAIL %s: got %h expected %h", name, got, exp));
  endtask

  task automatic check_unit(input string name, input unit_t got, input unit_t exp);
    if (got !== exp) abort_run($sformatf("FAIL %s: got %h expected %h", name, got, exp));
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) abort_run($sformatf("FAIL %s: got %h expected %h", name, got, exp));
  endtask

  // boundary operands five times in eight
  function automatic logic [XLEN-1:0] pick_operand();
    case ($unsigned($random(seed)) % 8)
      0: return '0;
      1: return 1;
      2: return '1;
      3: return {1'b1, {(XLEN-1){1'b0}}};
      4: return {1'b0, {(XLEN-1){1'b1}}};
      default: return {$random(seed), $random(seed)};
    endcase
  endfunction

  // next cycle, starts dropped, rob slots returned at random
  task automatic step_cycle();
    @(posedge clk);
    #1;
    alu_start  = 1'b0;
    ls_start   = 1'b0;
    rob_credit = 1'b0;
    if (hold_cycles > 0) begin
      hold_cycles--;
    end else if ($unsigned($random(seed)) % 32 == 0) begin
      // withhold slots for a stretch
      hold_cycles = 8 + $unsigned($random(seed)) % 32;
    end else if (rob_owed > 0 && $unsigned($random(seed)) % 2 == 0) begin
      rob_credit = 1'b1;
      rob_owed--;
      slots_free++;
    end
  endtask

  task automatic issue_alu(input alu_op_t op, input cond_t cond, input logic [XLEN-1:0] a,
                           input logic [XLEN-1:0] b, input logic [3:0] nzcv,
                           input logic sf);
    logic [XLEN+3:0] exp;
    exp           = alu_expect(op, cond, a, b, nzcv, sf);
    alu_op        = op;
    alu_cond      = cond;
    alu_a         = a;
    alu_b         = b;
    alu_nzcv_in   = nzcv;
    alu_set_flags = sf;
    alu_tag       = tag_next;
    alu_start     = 1'b1;
    alu_exp_q.push_back({sf, exp[XLEN+3:XLEN], tag_next, exp[XLEN-1:0]});
    tag_next++;
    alu_held--;
  endtask

  task automatic issue_ls(input ls_op_t op, input int word, input logic [XLEN-1:0] wdata);
    logic [XLEN-1:0] target;
    logic [XLEN-1:0] base;
    logic [XLEN-1:0] value;
    // random upper bits, word index in the bits the memory decodes
    target         = {$random(seed), $random(seed)};
    target[AW-1:3] = word[AW-4:0];
    target[2:0]    = 3'b000;
    base           = {$random(seed), $random(seed)};
    base[2:0]      = 3'b000;
    value          = ls_expect(op, target[AW-1:3], wdata);
    ls_op          = op;
    ls_base        = base;
    ls_offset      = target - base;
    ls_wdata       = wdata;
    ls_tag         = tag_next;
    ls_start       = 1'b1;
    ls_exp_q.push_back({1'b0, 4'b0000, tag_next, value});
    tag_next++;
    ls_held--;
  endtask

  task automatic send_alu(input alu_op_t op, input cond_t cond, input logic [XLEN-1:0] a,
                          input logic [XLEN-1:0] b, input logic [3:0] nzcv, input logic sf);
    int n;
    n = 0;
    step_cycle();
    while (alu_held == 0) begin
      if (n == TIMEOUT) begin
        abort_run("timeout waiting for an ALU issue credit");
      end else begin
        step_cycle();
        n++;
      end
    end
    issue_alu(op, cond, a, b, nzcv, sf);
  endtask

  task automatic send_ls(input ls_op_t op, input int word, input logic [XLEN-1:0] wdata);
    int n;
    n = 0;
    step_cycle();
    while (ls_held == 0) begin
      if (n == TIMEOUT) begin
        abort_run("timeout waiting for a load/store issue credit");
      end else begin
        step_cycle();
        n++;
      end
    end
    issue_ls(op, word, wdata);
  endtask

  task automatic check_writeback();
    logic [EXP_W-1:0] exp;
    unit_t            src;
    if (slots_free == 0) abort_run("rob_done fired while the ROB had no free slot");
    slots_free--;
    rob_owed++;
    // the unit whose oldest result carries this tag
    if (alu_exp_q.size() != 0 && alu_exp_q[0][XLEN +: ROB_IDX_W] == rob_tag) begin
      src = unit_alu;
    end else if (ls_exp_q.size() != 0 && ls_exp_q[0][XLEN +: ROB_IDX_W] == rob_tag) begin
      src = unit_lsu;
    end else begin
      src = rob_unit;
    end
    if (src == unit_alu && alu_exp_q.size() == 0) begin
      abort_run("ALU writeback with no ALU result outstanding");
    end else if (src == unit_lsu && ls_exp_q.size() == 0) begin
      abort_run("load/store writeback with no load/store result outstanding");
    end else begin
      exp = (src == unit_alu) ? alu_exp_q.pop_front() : ls_exp_q.pop_front();
      check_unit("rob_unit", rob_unit, src);
      check_tag("rob_tag", rob_tag, exp[XLEN +: ROB_IDX_W]);
      check_value("rob_value", rob_value, exp[XLEN-1:0]);
      check_nzcv("rob_nzcv", rob_nzcv, exp[XLEN+ROB_IDX_W +: 4]);
      check_flag("rob_set_flags", rob_set_flags, exp[EXP_W-1]);
    end
  endtask

  // outputs sampled mid-cycle, well clear of the driving edge
  always @(negedge clk) begin
    if (arst_n) begin
      if (alu_credit) begin
        if (alu_held == ALU_CREDITS) abort_run("ALU credit returned with none outstanding");
        alu_held++;
      end
      if (ls_credit) begin
        if (ls_held == LS_CREDITS) abort_run("load/store credit returned with none outstanding");
        ls_held++;
      end
      if (rob_done) check_writeback();
    end
  end

  initial begin
    int n;
    clk           = 1'b0;
    arst_n        = 1'b0;
    alu_start     = 1'b0;
    alu_op        = alu_plus;
    alu_cond      = cond_eq;
    alu_a         = '0;
    alu_b         = '0;
    alu_nzcv_in   = 4'b0000;
    alu_set_flags = 1'b0;
    alu_tag       = '0;
    ls_start      = 1'b0;
    ls_op         = ls_load;
    ls_base       = '0;
    ls_offset     = '0;
    ls_wdata      = '0;
    ls_tag        = '0;
    rob_credit    = 1'b0;
    alu_held      = ALU_CREDITS;
    ls_held       = LS_CREDITS;
    slots_free    = ROB_CREDITS;
    rob_owed      = 0;
    hold_cycles   = 0;
    tag_next      = '0;
    repeat (8) @(posedge clk);
    #1;
    arst_n = 1'b1;
    @(negedge clk);
    check_flag("rob_done", rob_done, 1'b0);
    check_flag("alu_credit", alu_credit, 1'b0);
    check_flag("ls_credit", ls_credit, 1'b0);

    // carry and overflow at the edges
    send_alu(alu_plus, cond_al, '1, 1, 4'b0000, 1'b1);
    send_alu(alu_plus, cond_al, {1'b0, {(XLEN-1){1'b1}}}, 1, 4'b0000, 1'b1);
    send_alu(alu_minus, cond_al, {1'b1, {(XLEN-1){1'b0}}}, 1, 4'b0000, 1'b1);
    send_alu(alu_minus, cond_al, '0, 1, 4'b0000, 1'b1);
    send_alu(alu_plus, cond_al, '1, 1, 4'b1010, 1'b0);
    // store then load back, plus an untouched word
    send_ls(ls_store, 3, 64'h0123_4567_89ab_cdef);
    send_ls(ls_load, 3, '0);
    send_ls(ls_load, 4, '0);
    send_ls(ls_store, 4, 64'hfeed_0000_beef_0001);
    send_ls(ls_load, 3, '0);
    send_ls(ls_load, 4, '0);

    // both units at random, small address window for reuse
    for (int i = 0; i < RAND_CYCLES; i++) begin
      step_cycle();
      if (alu_held > 0 && $unsigned($random(seed)) % 4 != 0) begin
        issue_alu(alu_op_t'(4'($unsigned($random(seed)) % 10)), cond_t'(4'($random(seed))),
                  pick_operand(), pick_operand(), 4'($random(seed)), 1'($random(seed)));
      end
      if (ls_held > 0 && $unsigned($random(seed)) % 2 == 0) begin
        issue_ls(ls_op_t'(1'($random(seed))), $unsigned($random(seed)) % 16,
                 {$random(seed), $random(seed)});
      end
    end

    // drain everything still in flight
    n = 0;
    step_cycle();
    while (alu_exp_q.size() != 0 || ls_exp_q.size() != 0) begin
      if (n == TIMEOUT) begin
        abort_run("timeout waiting for outstanding writebacks to drain");
      end else begin
        step_cycle();
        n++;
      end
    end
    if (alu_held != ALU_CREDITS) begin
      abort_run($sformatf("FAIL alu credits: got %h expected %h", alu_held, ALU_CREDITS));
    end else if (ls_held != LS_CREDITS) begin
      abort_run($sformatf("FAIL ls credits: got %h expected %h", ls_held, LS_CREDITS));
    end else begin
      $display("Simulation passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* func_units.f */
+incdir+dv
design/exec_pkg.sv
design/cond_eval.sv
design/alu_unit.sv
design/data_mem.sv
design/lsu_unit.sv
design/result_arbiter.sv
design/func_units.sv
dv/func_units_tb.sv

/* Bender.yml */
package:
  name: func_units

sources:
  - files:
      - design/exec_pkg.sv
      - design/cond_eval.sv
      - design/alu_unit.sv
      - design/data_mem.sv
      - design/lsu_unit.sv
      - design/result_arbiter.sv
      - design/func_units.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/func_units_tb.sv
